//--- design/drv_pkg.sv
// shared types and constants for the drive mechanics
//   drive model enum, loader state enum
//   track geometry and block counts
//   lba rule helpers
`default_nettype none

package drv_pkg;

	// drive model, 1541 single sided, 1571 double sided
	typedef enum logic [1:0] {
		M1541 = 2'd0,
		M1571 = 2'd1
	} drv_model_e;

	// track loader states
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		WAIT_SAVE = 3'd1,
		SAVE      = 3'd2,
		WAIT_LOAD = 3'd3,
		LOAD      = 3'd4,
		DONE      = 3'd5
	} loader_state_e;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	localparam logic [6:0] TRACK_MAX    = 7'd84;
	localparam logic [6:0] TRACK_HOME   = 7'd36;
	localparam logic [7:0] SIDE_OFFSET  = 8'd84;
	// 256-byte blocks per track image, scaled down
	localparam logic [5:0] BLK_CNT_1541 = 6'd2;
	localparam logic [5:0] BLK_CNT_1571 = 6'd3;

	// blocks per track for a model
	function automatic logic [5:0] blk_count(input drv_model_e model);
		return (model == M1571) ? BLK_CNT_1571 : BLK_CNT_1541;
	endfunction

	// lba = track index times blocks per track
	function automatic logic [31:0] track_lba(input logic [7:0] idx, input drv_model_e model);
		return 32'(idx) * 32'(blk_count(model));
	endfunction

endpackage

`default_nettype wire

//--- design/drv_track_if.sv
// track handshake between stepper, loader and head
//   track index and save toggle from the stepper
//   busy flag and valid length from the loader
`default_nettype none

interface drv_track_if;
	// half-track plus side offset
	logic [7:0] track_idx;
	// flips once per save request
	logic       save_tgl;
	// loader moving a track over sd
	logic       busy;
	// valid bytes in the track buffer
	logic [9:0] buf_len;

	modport stepper (output track_idx, output save_tgl, input busy);
	modport loader  (input track_idx, input save_tgl, output busy, output buf_len);
	modport head    (input busy, input buf_len);
endinterface

`default_nettype wire

//--- design/drv_media_ctrl.sv
// media and drive reset control
//   mount edge detect with readonly and present latches
//   write-protect sense with a change window after mount
//   drive reset held after a drive model change
`default_nettype none

module drv_media_ctrl
	import drv_pkg::*;
#(
	parameter int CHG_BITS   = 10,
	parameter int HOLD_TICKS = 64
) (
	input  wire             clk,
	input  wire             reset,
	input  wire             ce_i,
	input  wire             mount_i,
	input  wire             readonly_i,
	input  wire [31:0]      img_size_i,
	input  wire drv_model_e model_i,
	output logic            drv_reset_o,
	output logic            mount_pulse_o,
	output logic            disk_present_o,
	output logic            wps_n_o
);
	localparam int HOLD_W = $clog2(HOLD_TICKS + 1);

	logic                mount_q;
	logic                readonly_q;
	logic [CHG_BITS-1:0] chg_cnt;
	drv_model_e          model_q;
	logic                model_chg;
	logic [HOLD_W-1:0]   hold_cnt;

	// ----------------------------------------
	// mount and write protect
	// ----------------------------------------
	assign mount_pulse_o = mount_i & ~mount_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mount_q        <= 1'b0;
			readonly_q     <= 1'b0;
			disk_present_o <= 1'b0;
			chg_cnt        <= '0;
		end else begin
			mount_q <= mount_i;
			if (mount_pulse_o) begin
				readonly_q     <= readonly_i;
				// empty image means no disk
				disk_present_o <= |img_size_i;
				chg_cnt        <= '1;
			end else if (ce_i && chg_cnt != '0) begin
				chg_cnt <= chg_cnt - 1'b1;
			end
		end
	end

	// sense flipped in first half of window so the dos sees a disk change
	assign wps_n_o = ~readonly_q ^ chg_cnt[CHG_BITS-1];

	// ----------------------------------------
	// model change reset
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			model_q   <= model_i;
			model_chg <= 1'b0;
			hold_cnt  <= '0;
		end else begin
			model_q <= model_i;
			if (model_q != model_i) begin
				model_chg <= 1'b1;
				hold_cnt  <= HOLD_W'(HOLD_TICKS);
			end else if (hold_cnt != '0) begin
				if (ce_i)
					hold_cnt <= hold_cnt - 1'b1;
			end else begin
				// one extra cycle after the last tick
				model_chg <= 1'b0;
			end
		end
	end

	assign drv_reset_o = reset | model_chg;

endmodule

`default_nettype wire

//--- design/drv_stepper.sv
// head positioner
//   half-track from stepper phase differences
//   side offset into the track index
//   modified-track tracking and save toggle
`default_nettype none

module drv_stepper
	import drv_pkg::*;
(
	input  wire          clk,
	input  wire          drv_reset_i,
	input  wire          mount_pulse_i,
	input  wire [1:0]    stp_i,
	input  wire          mtr_i,
	input  wire          act_i,
	input  wire          side_i,
	input  wire          track_write_i,
	drv_track_if.stepper trk
);
	logic [1:0] stp_q;
	logic [1:0] move;
	logic [6:0] half_trk;
	logic       side_q;
	logic       act_q;
	logic       modified;
	logic       save_due;
	logic       save_tgl;
	logic [7:0] track_idx;
	logic       step_in;
	logic       step_out;
	logic       save_evt;

	// phase moved one forward or one back
	assign step_in  = mtr_i && (move == 2'd1);
	assign step_out = mtr_i && (move == 2'd3);

	// leaving a dirty track, by step, side switch or activity end
	assign save_evt = modified &&
		(step_in || step_out || (side_i != side_q) || (act_q && !act_i));

	always_ff @(posedge clk) begin
		if (drv_reset_i) begin
			stp_q     <= stp_i;
			move      <= 2'd0;
			half_trk  <= TRACK_HOME;
			side_q    <= 1'b0;
			act_q     <= 1'b0;
			modified  <= 1'b0;
			save_due  <= 1'b0;
			save_tgl  <= 1'b0;
			track_idx <= {1'b0, TRACK_HOME};
		end else begin
			stp_q  <= stp_i;
			move   <= stp_i - stp_q;
			side_q <= side_i;
			act_q  <= act_i;

			// clamped head movement
			if (step_in && half_trk < TRACK_MAX)
				half_trk <= half_trk + 1'b1;
			if (step_out && half_trk != 7'd0)
				half_trk <= half_trk - 1'b1;

			// side 1 tracks follow the side 0 ones
			track_idx <= {1'b0, half_trk} + (side_i ? SIDE_OFFSET : 8'd0);

			if (track_write_i)
				modified <= 1'b1;

			// toggle now, or hold it until the loader is free
			if (save_evt || save_due) begin
				if (save_evt)
					modified <= 1'b0;
				if (!trk.busy) begin
					save_tgl <= ~save_tgl;
					save_due <= 1'b0;
				end else begin
					save_due <= 1'b1;
				end
			end

			// new image, old changes are dropped
			if (mount_pulse_i) begin
				modified <= 1'b0;
				save_due <= 1'b0;
			end
		end
	end

	assign trk.track_idx = track_idx;
	assign trk.save_tgl  = save_tgl;

endmodule

`default_nettype wire

//--- design/drv_track_loader.sv
// track loader
//   fsm that writes back a dirty track then reads the new one
//   sd block port requests with level handshake
//   busy flag and valid buffer length
`default_nettype none

module drv_track_loader
	import drv_pkg::*;
(
	input  wire             clk,
	input  wire             drv_reset_i,
	input  wire drv_model_e model_i,
	input  wire             disk_present_i,
	input  wire             mount_pulse_i,
	output logic [31:0]     sd_lba_o,
	output logic [5:0]      sd_blk_cnt_o,
	output logic            sd_rd_o,
	output logic            sd_wr_o,
	input  wire             sd_ack_i,
	drv_track_if.loader     trk
);
	// marks that no track is in the buffer
	localparam logic [7:0] NO_TRACK = 8'hff;

	loader_state_e state;
	logic [7:0]    loaded_idx;
	logic [7:0]    target_idx;
	logic          save_seen;
	logic          save_pend;
	logic          load_pend;
	logic          busy;
	logic          save_flip;
	logic          save_req;
	logic          load_req;
	logic [5:0]    blk_cnt;

	assign blk_cnt      = blk_count(model_i);
	assign sd_blk_cnt_o = blk_cnt - 6'd1;
	assign trk.buf_len  = disk_present_i ? (10'(blk_cnt) << 8) : 10'd0;
	assign trk.busy     = busy;

	assign save_flip = trk.save_tgl != save_seen;
	// nothing to write back without a loaded track
	assign save_req  = (save_pend || save_flip) && loaded_idx != NO_TRACK;
	assign load_req  = load_pend || mount_pulse_i || (trk.track_idx != loaded_idx);

	always_ff @(posedge clk) begin
		if (drv_reset_i) begin
			state      <= IDLE;
			busy       <= 1'b0;
			sd_rd_o    <= 1'b0;
			sd_wr_o    <= 1'b0;
			sd_lba_o   <= '0;
			loaded_idx <= NO_TRACK;
			target_idx <= '0;
			save_seen  <= 1'b0;
			save_pend  <= 1'b0;
			load_pend  <= 1'b0;
		end else begin
			// keep requests until serviced
			if (save_flip) begin
				save_seen <= trk.save_tgl;
				save_pend <= 1'b1;
			end
			if (mount_pulse_i) begin
				load_pend  <= 1'b1;
				save_pend  <= 1'b0;
				loaded_idx <= NO_TRACK;
			end

			unique case (state)
				IDLE: begin
					if (disk_present_i) begin
						// save first, always to the old track
						if (save_req) begin
							state     <= WAIT_SAVE;
							busy      <= 1'b1;
							sd_wr_o   <= 1'b1;
							sd_lba_o  <= track_lba(loaded_idx, model_i);
							save_pend <= 1'b0;
						end else if (load_req) begin
							state      <= WAIT_LOAD;
							busy       <= 1'b1;
							sd_rd_o    <= 1'b1;
							target_idx <= trk.track_idx;
							sd_lba_o   <= track_lba(trk.track_idx, model_i);
							load_pend  <= 1'b0;
						end
					end
				end
				WAIT_SAVE: begin
					if (sd_ack_i) begin
						sd_wr_o <= 1'b0;
						state   <= SAVE;
					end
				end
				SAVE: begin
					// block moves while ack is high
					if (!sd_ack_i) begin
						if (load_req) begin
							state      <= WAIT_LOAD;
							sd_rd_o    <= 1'b1;
							target_idx <= trk.track_idx;
							sd_lba_o   <= track_lba(trk.track_idx, model_i);
							load_pend  <= 1'b0;
						end else begin
							state <= DONE;
						end
					end
				end
				WAIT_LOAD: begin
					if (sd_ack_i) begin
						sd_rd_o <= 1'b0;
						state   <= LOAD;
					end
				end
				LOAD: begin
					if (!sd_ack_i) begin
						loaded_idx <= target_idx;
						state      <= DONE;
					end
				end
				DONE: begin
					busy  <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/drv_head.sv
// read/write head
//   dual-port track buffer, sd fill and drain
//   zone bit-rate divider
//   read bit stream msb first, write shifter, index pulse
`default_nettype none

module drv_head #(
	parameter int BUF_BLKS = 3
) (
	input  wire        clk,
	input  wire        ce_i,
	input  wire        drv_reset_i,
	input  wire        disk_present_i,
	input  wire        mtr_i,
	input  wire [1:0]  zone_i,
	input  wire        wgate_i,
	input  wire        wbit_i,
	input  wire        sd_ack_i,
	input  wire [15:0] sd_buff_addr_i,
	input  wire [7:0]  sd_buff_dout_i,
	input  wire        sd_buff_wr_i,
	output logic [7:0] sd_buff_din_o,
	output logic       hclk_o,
	output logic       hbit_o,
	output logic       index_o,
	output logic       track_write_o,
	drv_track_if.head  trk
);
	localparam int BUF_BYTES = BUF_BLKS * 256;
	localparam int AW        = $clog2(BUF_BYTES);

	logic [7:0]    mem [BUF_BYTES];
	logic [AW-1:0] sd_addr;
	logic          sd_we;
	logic [3:0]    div;
	logic [3:0]    period_m1;
	logic          run;
	logic          bit_tick;
	logic          byte_end;
	logic [AW-1:0] ptr;
	logic [AW-1:0] ptr_next;
	logic          ptr_wrap;
	logic [2:0]    bit_cnt;
	logic [7:0]    rd_byte;
	logic [7:0]    rd_shift;
	logic [7:0]    wr_shift;
	logic          head_we;

	// sd writes only inside the buffer
	assign sd_addr = sd_buff_addr_i[AW-1:0];
	assign sd_we   = sd_ack_i && sd_buff_wr_i && (sd_buff_addr_i < 16'(BUF_BYTES));

	// 16 - 2*zone ce ticks per bit
	assign period_m1 = 4'd15 - {zone_i, 1'b0};
	assign run       = mtr_i && disk_present_i && !trk.busy && (trk.buf_len != 10'd0);
	assign bit_tick  = ce_i && (div == 4'd0) && run;
	assign byte_end  = bit_tick && (bit_cnt == 3'd7);
	assign head_we   = byte_end && wgate_i;

	// wrap at the valid length, not the buffer size
	assign ptr_wrap = (32'(ptr) + 32'd1) >= 32'(trk.buf_len);
	assign ptr_next = ptr_wrap ? '0 : ptr + 1'b1;

	// ----------------------------------------
	// track buffer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (sd_we)
			mem[sd_addr] <= sd_buff_dout_i;
		// written byte replaces the one under the head
		if (head_we)
			mem[ptr] <= {wr_shift[6:0], wbit_i};
		sd_buff_din_o <= mem[sd_addr];
		rd_byte       <= mem[ptr];
	end

	// shifters
	always_ff @(posedge clk) begin
		if (bit_tick) begin
			if (bit_cnt == 3'd0)
				rd_shift <= {rd_byte[6:0], 1'b0};
			else
				rd_shift <= {rd_shift[6:0], 1'b0};
			if (wgate_i)
				wr_shift <= {wr_shift[6:0], wbit_i};
		end
	end

	// ----------------------------------------
	// bit timing and byte pointer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (drv_reset_i) begin
			div           <= 4'd0;
			ptr           <= '0;
			bit_cnt       <= 3'd0;
			hclk_o        <= 1'b0;
			hbit_o        <= 1'b0;
			index_o       <= 1'b0;
			track_write_o <= 1'b0;
		end else begin
			hclk_o        <= 1'b0;
			index_o       <= 1'b0;
			track_write_o <= 1'b0;
			if (ce_i)
				div <= (div == 4'd0) ? period_m1 : div - 1'b1;

			// new track starts from byte 0
			if (trk.busy) begin
				ptr     <= '0;
				bit_cnt <= 3'd0;
			end else if (bit_tick) begin
				hclk_o  <= 1'b1;
				bit_cnt <= bit_cnt + 1'b1;
				hbit_o  <= (bit_cnt == 3'd0) ? rd_byte[7] : rd_shift[7];
				if (byte_end) begin
					ptr           <= ptr_next;
					index_o       <= ptr_wrap;
					track_write_o <= wgate_i;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/drv_top.sv
// drive mechanics top level
//   media control, stepper, track loader and head
//   track interface between the blocks
//   activity led
`default_nettype none

module drv_top
	import drv_pkg::*;
#(
	parameter int CHG_BITS   = 10,
	parameter int HOLD_TICKS = 64,
	// at least BLK_CNT_1571
	parameter int BUF_BLKS   = 3
) (
	input  wire             clk,
	input  wire             reset,
	input  wire             ce_i,
	// image control
	input  wire             mount_i,
	input  wire             readonly_i,
	input  wire [31:0]      img_size_i,
	input  wire drv_model_e model_i,
	// from the drive controller
	input  wire [1:0]       stp_i,
	input  wire             mtr_i,
	input  wire             act_i,
	input  wire             side_i,
	input  wire             wgate_i,
	input  wire [1:0]       zone_i,
	input  wire             wbit_i,
	// to the drive controller
	output logic            wps_n_o,
	output logic            led_o,
	output logic            hclk_o,
	output logic            hbit_o,
	output logic            index_o,
	// sd block port
	output logic [31:0]     sd_lba_o,
	output logic [5:0]      sd_blk_cnt_o,
	output logic            sd_rd_o,
	output logic            sd_wr_o,
	input  wire             sd_ack_i,
	input  wire [15:0]      sd_buff_addr_i,
	input  wire [7:0]       sd_buff_dout_i,
	output logic [7:0]      sd_buff_din_o,
	input  wire             sd_buff_wr_i
);
	logic drv_reset;
	logic mount_pulse;
	logic disk_present;
	logic track_write;

	drv_track_if trk ();

	drv_media_ctrl #(
		.CHG_BITS   (CHG_BITS),
		.HOLD_TICKS (HOLD_TICKS)
	) i_media_ctrl (
		.clk            (clk),
		.reset          (reset),
		.ce_i           (ce_i),
		.mount_i        (mount_i),
		.readonly_i     (readonly_i),
		.img_size_i     (img_size_i),
		.model_i        (model_i),
		.drv_reset_o    (drv_reset),
		.mount_pulse_o  (mount_pulse),
		.disk_present_o (disk_present),
		.wps_n_o        (wps_n_o)
	);

	drv_stepper i_stepper (
		.clk           (clk),
		.drv_reset_i   (drv_reset),
		.mount_pulse_i (mount_pulse),
		.stp_i         (stp_i),
		.mtr_i         (mtr_i),
		.act_i         (act_i),
		.side_i        (side_i),
		.track_write_i (track_write),
		.trk           (trk.stepper)
	);

	drv_track_loader i_loader (
		.clk            (clk),
		.drv_reset_i    (drv_reset),
		.model_i        (model_i),
		.disk_present_i (disk_present),
		.mount_pulse_i  (mount_pulse),
		.sd_lba_o       (sd_lba_o),
		.sd_blk_cnt_o   (sd_blk_cnt_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_ack_i       (sd_ack_i),
		.trk            (trk.loader)
	);

	drv_head #(
		.BUF_BLKS (BUF_BLKS)
	) i_head (
		.clk            (clk),
		.ce_i           (ce_i),
		.drv_reset_i    (drv_reset),
		.disk_present_i (disk_present),
		.mtr_i          (mtr_i),
		.zone_i         (zone_i),
		.wgate_i        (wgate_i),
		.wbit_i         (wbit_i),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_din_o  (sd_buff_din_o),
		.hclk_o         (hclk_o),
		.hbit_o         (hbit_o),
		.index_o        (index_o),
		.track_write_o  (track_write),
		.trk            (trk.head)
	);

	// lit while the controller is active or a track is moving
	assign led_o = act_i | trk.busy;

endmodule

`default_nettype wire

//--- dv/drv_checker.sv
// protocol assertions for the drive mechanics
//   sd request exclusivity and lba stability
//   one-cycle hclk and index pulses
//   bind onto the top level
`default_nettype none

module drv_checker (
	input  wire        clk,
	input  wire        reset,
	input  wire        sd_rd_i,
	input  wire        sd_wr_i,
	input  wire        sd_ack_i,
	input  wire [31:0] sd_lba_i,
	input  wire        hclk_i,
	input  wire        index_i
);

	// ----------------------------------------
	// sd block port
	// ----------------------------------------
	// read and write never requested together
	rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(sd_rd_i && sd_wr_i))
		else $error("sd read and write requested together");

	// lba held while waiting for ack
	lba_stable: assert property (@(posedge clk) disable iff (reset)
		((sd_rd_i || sd_wr_i) && !sd_ack_i) |=> $stable(sd_lba_i))
		else $error("sd lba changed while a request was pending");

	// ----------------------------------------
	// head outputs
	// ----------------------------------------
	hclk_pulse: assert property (@(posedge clk) disable iff (reset)
		hclk_i |=> !hclk_i)
		else $error("hclk longer than one cycle");

	index_pulse: assert property (@(posedge clk) disable iff (reset)
		index_i |=> !index_i)
		else $error("index longer than one cycle");

endmodule

bind drv_top drv_checker i_checker (
	.clk      (clk),
	.reset    (reset),
	.sd_rd_i  (sd_rd_o),
	.sd_wr_i  (sd_wr_o),
	.sd_ack_i (sd_ack_i),
	.sd_lba_i (sd_lba_o),
	.hclk_i   (hclk_o),
	.index_i  (index_o)
);

`default_nettype wire

//--- dv/drv_tb.sv
// testbench for the drive mechanics
//   clock, reset, ce and sd block model with random latency
//   mount, stepping, read stream, write back, write protect, model change
//   error counting and closing line
`default_nettype none

module drv_tb
	import drv_pkg::*;
;
	logic        clk;
	logic        reset;
	logic        ce_i;
	logic        mount_i;
	logic        readonly_i;
	logic [31:0] img_size_i;
	drv_model_e  model_i;
	logic [1:0]  stp_i;
	logic        mtr_i;
	logic        act_i;
	logic        side_i;
	logic        wgate_i;
	logic [1:0]  zone_i;
	logic        wbit_i;
	logic        wps_n_o;
	logic        led_o;
	logic        hclk_o;
	logic        hbit_o;
	logic        index_o;
	logic [31:0] sd_lba_o;
	logic [5:0]  sd_blk_cnt_o;
	logic        sd_rd_o;
	logic        sd_wr_o;
	logic        sd_ack_i;
	logic [15:0] sd_buff_addr_i;
	logic [7:0]  sd_buff_dout_i;
	logic [7:0]  sd_buff_din_o;
	logic        sd_buff_wr_i;

	int          errors;
	int          checks;
	// sd model bookkeeping
	int          rd_count;
	int          wr_count;
	int          op_seq;
	int          rd_seq;
	int          wr_seq;
	logic [31:0] last_rd_lba;
	logic [31:0] last_wr_lba;
	logic [5:0]  last_rd_blk;
	logic [7:0]  wr_data [768];
	logic [31:0] rnd;
	// expected head position
	int          exp_ht;
	int          exp_blk;
	event        timeout_ev;

	drv_top i_drv_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ce every second cycle
	always @(negedge clk) ce_i <= ~ce_i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
		-> timeout_ev;
	endtask

	// ----------------------------------------
	// sd block model
	// ----------------------------------------
	task automatic serve_sd();
		logic        is_rd;
		logic [31:0] lba;
		int          nbytes;
		int          i;
		is_rd  = sd_rd_o;
		lba    = sd_lba_o;
		nbytes = (int'(sd_blk_cnt_o) + 1) * 256;
		op_seq++;
		if (is_rd) begin
			rd_count++;
			rd_seq      = op_seq;
			last_rd_lba = lba;
			last_rd_blk = sd_blk_cnt_o;
		end else begin
			wr_count++;
			wr_seq      = op_seq;
			last_wr_lba = lba;
		end
		rnd = xorshift(rnd);
		repeat (int'(rnd[2:0])) @(negedge clk);
		sd_ack_i = 1'b1;
		if (is_rd) begin
			for (i = 0; i < nbytes; i++) begin
				sd_buff_addr_i = i[15:0];
				sd_buff_dout_i = lba[7:0] + i[7:0];
				sd_buff_wr_i   = 1'b1;
				@(negedge clk);
			end
			sd_buff_wr_i = 1'b0;
		end else begin
			// read data lags the address by one cycle
			for (i = 0; i <= nbytes; i++) begin
				if (i > 0 && i <= 768)
					wr_data[i-1] = sd_buff_din_o;
				if (i < nbytes)
					sd_buff_addr_i = i[15:0];
				@(negedge clk);
			end
		end
		sd_ack_i = 1'b0;
		@(negedge clk);
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (!reset && (sd_rd_o || sd_wr_o))
				serve_sd();
		end
	end

	// ----------------------------------------
	// waits
	// ----------------------------------------
	task automatic wait_reads(input int n);
		int t;
		t = 0;
		while (rd_count < n && t < 20000) begin
			@(negedge clk);
			t++;
		end
		if (rd_count < n)
			report_timeout("an sd read request");
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while ((led_o || sd_rd_o || sd_wr_o || sd_ack_i) && t < 20000) begin
			@(negedge clk);
			t++;
		end
		if (led_o || sd_rd_o || sd_wr_o || sd_ack_i)
			report_timeout("the loader to go idle");
	endtask

	task automatic wait_hclk();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!hclk_o && t < 1000);
		if (!hclk_o)
			report_timeout("a head bit clock");
	endtask

	task automatic wait_index();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!index_o && t < 200000);
		if (!index_o)
			report_timeout("an index pulse");
	endtask

	task automatic read_byte(output logic [7:0] b);
		int k;
		b = 8'h00;
		for (k = 0; k < 8; k++) begin
			wait_hclk();
			b = {b[6:0], hbit_o};
		end
	endtask

	function automatic logic [31:0] exp_lba();
		return 32'((exp_ht + (side_i ? 84 : 0)) * exp_blk);
	endfunction

	// one phase step in the direction of dir, with the drive's clamp at both ends
	task automatic step_head(input int dir);
		int prev;
		int target;
		prev   = rd_count;
		target = exp_ht + dir;
		if (target < 0)
			target = 0;
		if (target > int'(TRACK_MAX))
			target = int'(TRACK_MAX);
		stp_i = stp_i + ((dir > 0) ? 2'd1 : 2'd3);
		if (target != exp_ht) begin
			exp_ht = target;
			wait_reads(prev + 1);
			wait_idle();
			check_val("step lba", exp_lba(), last_rd_lba);
		end else begin
			repeat (20) @(negedge clk);
			check_val("clamp no read", 32'(prev), 32'(rd_count));
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		logic [7:0]  b;
		logic [7:0]  exp_b;
		logic [15:0] pat;
		logic [31:0] old_lba;
		int          prev;
		int          prev_w;
		int          bits;
		int          k;
		int          t;
		errors = 0;
		checks = 0;
		rd_count = 0;
		wr_count = 0;
		op_seq = 0;
		rd_seq = 0;
		wr_seq = 0;
		last_rd_lba = '0;
		last_wr_lba = '0;
		last_rd_blk = '0;
		rnd = 32'hc05a;
		reset = 1'b1;
		ce_i = 1'b0;
		mount_i = 1'b0;
		readonly_i = 1'b0;
		img_size_i = 32'd0;
		model_i = M1541;
		stp_i = 2'd0;
		mtr_i = 1'b0;
		act_i = 1'b0;
		side_i = 1'b0;
		wgate_i = 1'b0;
		zone_i = 2'd3;
		wbit_i = 1'b0;
		sd_ack_i = 1'b0;
		sd_buff_addr_i = 16'd0;
		sd_buff_dout_i = 8'd0;
		sd_buff_wr_i = 1'b0;
		exp_ht = int'(TRACK_HOME);
		exp_blk = int'(BLK_CNT_1541);
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// reset state and mounts
		check_val("reset rd", 0, 32'(sd_rd_o));
		check_val("reset wr", 0, 32'(sd_wr_o));
		check_val("reset led", 0, 32'(led_o));
		check_val("reset index", 0, 32'(index_o));
		mount_i = 1'b1;
		repeat (20) @(negedge clk);
		check_val("empty mount", 0, 32'(rd_count));
		mount_i = 1'b0;
		img_size_i = 32'h0002_0000;
		@(negedge clk);
		mount_i = 1'b1;
		wait_reads(1);
		check_val("busy led", 1, 32'(led_o));
		wait_idle();
		check_val("mount lba", exp_lba(), last_rd_lba);
		check_val("mount blk cnt", 32'(BLK_CNT_1541 - 6'd1), 32'(last_rd_blk));
		check_val("mount reads", 1, 32'(rd_count));
		mount_i = 1'b0;
		act_i = 1'b1;
		@(negedge clk);
		check_val("act led", 1, 32'(led_o));
		act_i = 1'b0;

		// stepping with the motor off first
		stp_i = stp_i + 2'd1;
		repeat (20) @(negedge clk);
		check_val("motor off", 1, 32'(rd_count));
		mtr_i = 1'b1;
		repeat (3) step_head(1);
		repeat (3) step_head(-1);
		repeat (38) step_head(-1);
		repeat (86) step_head(1);
		prev = rd_count;
		side_i = 1'b1;
		wait_reads(prev + 1);
		wait_idle();
		check_val("side 1 lba", exp_lba(), last_rd_lba);
		side_i = 1'b0;
		wait_reads(prev + 2);
		wait_idle();
		check_val("side 0 lba", exp_lba(), last_rd_lba);

		// read stream from the index
		old_lba = exp_lba();
		wait_index();
		for (k = 0; k < 16; k++) begin
			read_byte(b);
			exp_b = old_lba[7:0] + k[7:0];
			check_val("hbit byte", 32'(exp_b), 32'(b));
		end
		wait_index();
		bits = 0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (hclk_o)
				bits++;
		end while (!index_o && t < 200000);
		if (!index_o)
			report_timeout("the second index pulse");
		check_val("index spacing", 32'(exp_blk * 256 * 8), 32'(bits));

		// write two bytes and step out to save them
		pat = 16'ha53c;
		wait_index();
		wgate_i = 1'b1;
		wbit_i = pat[15];
		for (k = 0; k < 16; k++) begin
			wait_hclk();
			if (k < 15)
				wbit_i = pat[14 - k];
		end
		wgate_i = 1'b0;
		prev_w = wr_count;
		step_head(-1);
		check_val("save count", 32'(prev_w + 1), 32'(wr_count));
		check_val("save before load", 1, 32'(wr_seq < rd_seq));
		check_val("save lba", old_lba, last_wr_lba);
		check_val("save byte 0", 32'h a5, 32'(wr_data[0]));
		check_val("save byte 1", 32'h3c, 32'(wr_data[1]));
		exp_b = old_lba[7:0] + 8'd2;
		check_val("save byte 2", 32'(exp_b), 32'(wr_data[2]));

		// write-protect change window of 1024 ce ticks
		readonly_i = 1'b1;
		mount_i = 1'b1;
		repeat (200) @(negedge clk);
		check_val("wps early", 1, 32'(wps_n_o));
		repeat (2000) @(negedge clk);
		check_val("wps after", 0, 32'(wps_n_o));
		wait_idle();
		mount_i = 1'b0;

		// model change goes home and loads 1571 geometry
		prev = rd_count;
		model_i = M1571;
		exp_blk = int'(BLK_CNT_1571);
		exp_ht = int'(TRACK_HOME);
		wait_reads(prev + 1);
		wait_idle();
		check_val("model lba", exp_lba(), last_rd_lba);
		check_val("model blk cnt", 32'(BLK_CNT_1571 - 6'd1), 32'(last_rd_blk));
		step_head(1);

		repeat (10) @(negedge clk);
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		@(timeout_ev);
		$display("checks: %0d errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
design/drv_pkg.sv
design/drv_track_if.sv
design/drv_media_ctrl.sv
design/drv_stepper.sv
design/drv_track_loader.sv
design/drv_head.sv
design/drv_top.sv
dv/drv_checker.sv
dv/drv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the drive mechanics testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module drv_tb \
	-Mdir obj_dir -o Vdrv_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vdrv_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
if ! grep -q "No errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
